/* hw/rename_pkg.sv */
package rename_pkg;

    // ========================================
    // architectural register space
    // ========================================
    localparam int arch_regs = 32;   // x0..x31, x0 hardwired to p0
    localparam int areg_w    = 5;    // bits to index an arch reg

    // ========================================
    // physical register space
    // ========================================
    localparam int phys_regs = 64;   // p0 plus 63 renameable
    localparam int preg_w    = 6;    // bits to index a phys reg

    // ========================================
    // datapath
    // ========================================
    localparam int xlen       = 32;  // integer data width
    localparam int read_ports = 4;   // issue stage operand reads

    // after reset the map is the identity, so
    // p0..p31 hold the arch state and p32..p63 start free
    // single writeback port, single commit port

endpackage

/* hw/phys_regfile.sv */
`timescale 1ns/100ps

module phys_regfile (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  logic                                                   wr_en,
    input  logic [rename_pkg::preg_w-1:0]                          wr_addr,
    input  logic [rename_pkg::xlen-1:0]                            wr_data,
    input  logic [rename_pkg::read_ports-1:0][rename_pkg::preg_w-1:0] rd_addr,
    output logic [rename_pkg::read_ports-1:0][rename_pkg::xlen-1:0]   rd_data
);
    import rename_pkg::*;

    logic [xlen-1:0] regs [phys_regs];   // one entry per phys reg
    logic            wr_live;            // write that really lands

    // ========================================
    // write side
    // ========================================
    assign wr_live = wr_en && (wr_addr != '0);   // p0 is read only

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++) begin
                regs[i] <= '0;                   // p0 stays zero forever
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;            // lands at the edge
        end
    end

    // ========================================
    // read side with bypass
    // ========================================
    always_comb begin
        for (int p = 0; p < read_ports; p++) begin
            if (wr_live && (rd_addr[p] == wr_addr)) begin
                rd_data[p] = wr_data;            // same-cycle writeback
            end else begin
                rd_data[p] = regs[rd_addr[p]];   // stored value
            end
        end
    end

    // the free list never hands out p0, so no producer may target it
    a_no_write_p0: assert property (
        @(posedge clock) disable iff (reset)
        wr_en |-> (wr_addr != '0)
    ) else $error("phys_regfile: write to p0");

endmodule

/* hw/free_list.sv */
`timescale 1ns/100ps

module free_list (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          pop,
    output logic [rename_pkg::preg_w-1:0] pop_pd,
    output logic                          empty,
    input  logic                          push,
    input  logic [rename_pkg::preg_w-1:0] push_pd
);
    import rename_pkg::*;

    logic [preg_w-1:0] slots [phys_regs];   // ring of free phys numbers
    logic [preg_w-1:0] head;                // next to hand out
    logic [preg_w-1:0] tail;                // next free slot
    logic [preg_w:0]   count;               // 0..phys_regs, msb means full

    // ========================================
    // outputs
    // ========================================
    assign pop_pd = slots[head];            // valid whenever not empty
    assign empty  = (count == '0);

    // ========================================
    // ring storage
    // ========================================
    always_ff @(posedge clock) begin
        if (reset) begin
            // low half gets p32..p63 in order
            for (int i = 0; i < phys_regs - arch_regs; i++) begin
                slots[i] <= preg_w'(arch_regs + i);
            end
        end else if (push) begin
            slots[tail] <= push_pd;         // retired old mapping
        end
    end

    // ========================================
    // pointers and occupancy
    // ========================================
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= preg_w'(phys_regs - arch_regs);   // just past p63
            count <= {1'b0, preg_w'(phys_regs - arch_regs)};
        end else begin
            if (pop) begin
                head <= head + 1'b1;        // wraps, power of two depth
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // rename side must hold off while empty
    a_no_underflow: assert property (
        @(posedge clock) disable iff (reset)
        pop |-> !empty
    ) else $error("free_list: pop while empty");

    // more frees than phys regs means a double commit
    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset)
        (push && !pop) |-> !count[preg_w]
    ) else $error("free_list: push while full");

    // commit path filters p0 before it gets here
    a_no_push_p0: assert property (
        @(posedge clock) disable iff (reset)
        push |-> (push_pd != '0)
    ) else $error("free_list: p0 pushed");

endmodule

/* hw/rename_map.sv */
`timescale 1ns/100ps

module rename_map (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          ren_fire,
    input  logic [rename_pkg::areg_w-1:0] rd,
    input  logic [rename_pkg::areg_w-1:0] rs1,
    input  logic [rename_pkg::areg_w-1:0] rs2,
    input  logic [rename_pkg::preg_w-1:0] new_pd,
    output logic [rename_pkg::preg_w-1:0] ps1,
    output logic [rename_pkg::preg_w-1:0] ps2,
    output logic [rename_pkg::preg_w-1:0] pd_old,
    output logic                          ps1_ready,
    output logic                          ps2_ready,
    input  logic                          wb_valid,
    input  logic [rename_pkg::preg_w-1:0] wb_pd
);
    import rename_pkg::*;

    logic [preg_w-1:0]    map [arch_regs];   // arch to phys table
    logic [phys_regs-1:0] busy;              // set = value not produced yet
    logic                 map_wr;            // rename that updates the table

    assign map_wr = ren_fire && (rd != '0);  // x0 never remapped

    // ========================================
    // lookups, before this instruction's update
    // ========================================
    assign ps1    = map[rs1];
    assign ps2    = map[rs2];
    assign pd_old = map[rd];                 // p0 for rd of x0

    // busy clear, or being written back right now
    assign ps1_ready = !busy[ps1] || (wb_valid && (wb_pd == ps1));
    assign ps2_ready = !busy[ps2] || (wb_valid && (wb_pd == ps2));

    // ========================================
    // map table
    // ========================================
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= preg_w'(i);        // identity mapping
            end
        end else if (map_wr) begin
            map[rd] <= new_pd;               // newest producer of rd
        end
    end

    // ========================================
    // busy bits
    // ========================================
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;                      // arch state all produced
        end else begin
            if (wb_valid) begin
                busy[wb_pd] <= 1'b0;         // result arrived
            end
            if (map_wr) begin
                busy[new_pd] <= 1'b1;        // later assignment wins
            end
        end
    end

    // a register from the free list has had its value produced and retired
    a_alloc_not_busy: assert property (
        @(posedge clock) disable iff (reset)
        map_wr |-> ((new_pd != '0) && !busy[new_pd])
    ) else $error("rename_map: allocated p%0d still busy", new_pd);

endmodule

/* hw/rename_core.sv */
`timescale 1ns/100ps

module rename_core (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  logic                                                   ren_valid,
    input  logic [rename_pkg::areg_w-1:0]                          ren_rd,
    input  logic [rename_pkg::areg_w-1:0]                          ren_rs1,
    input  logic [rename_pkg::areg_w-1:0]                          ren_rs2,
    output logic                                                   ren_ready,
    output logic [rename_pkg::preg_w-1:0]                          ren_ps1,
    output logic [rename_pkg::preg_w-1:0]                          ren_ps2,
    output logic                                                   ren_ps1_ready,
    output logic                                                   ren_ps2_ready,
    output logic [rename_pkg::preg_w-1:0]                          ren_pd,
    output logic [rename_pkg::preg_w-1:0]                          ren_pd_old,
    input  logic                                                   wb_valid,
    input  logic [rename_pkg::preg_w-1:0]                          wb_pd,
    input  logic [rename_pkg::xlen-1:0]                            wb_data,
    input  logic                                                   cm_valid,
    input  logic [rename_pkg::preg_w-1:0]                          cm_pd_old,
    input  logic [rename_pkg::read_ports-1:0][rename_pkg::preg_w-1:0] rd_addr,
    output logic [rename_pkg::read_ports-1:0][rename_pkg::xlen-1:0]   rd_data
);
    import rename_pkg::*;

    logic              rd_nonzero;   // instruction needs a new reg
    logic              ren_fire;     // handshake this cycle
    logic              fl_pop;
    logic              fl_push;
    logic              fl_empty;
    logic [preg_w-1:0] fl_pd;        // head of the free list

    // ========================================
    // rename handshake
    // ========================================
    assign rd_nonzero = (ren_rd != '0);
    assign ren_ready  = !reset && (!fl_empty || !rd_nonzero);   // held low in reset
    assign ren_fire   = ren_valid && ren_ready;
    assign fl_pop     = ren_fire && rd_nonzero;                 // x0 takes nothing
    assign fl_push    = cm_valid && (cm_pd_old != '0);          // p0 never freed
    assign ren_pd     = rd_nonzero ? fl_pd : '0;

    rename_map u_map (
        .clock     (clock),
        .reset     (reset),
        .ren_fire  (ren_fire),
        .rd        (ren_rd),
        .rs1       (ren_rs1),
        .rs2       (ren_rs2),
        .new_pd    (fl_pd),
        .ps1       (ren_ps1),
        .ps2       (ren_ps2),
        .pd_old    (ren_pd_old),
        .ps1_ready (ren_ps1_ready),
        .ps2_ready (ren_ps2_ready),
        .wb_valid  (wb_valid),
        .wb_pd     (wb_pd)
    );

    free_list u_free (
        .clock   (clock),
        .reset   (reset),
        .pop     (fl_pop),
        .pop_pd  (fl_pd),
        .empty   (fl_empty),
        .push    (fl_push),
        .push_pd (cm_pd_old)
    );

    phys_regfile u_prf (
        .clock   (clock),
        .reset   (reset),
        .wr_en   (wb_valid),
        .wr_addr (wb_pd),
        .wr_data (wb_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* sim/rename_core_tb.sv */
`timescale 1ns/100ps

module rename_core_tb;
    import rename_pkg::*;

    // one golden line, one cycle
    typedef struct packed {
        logic [3:0]                           test;
        logic                                 valid;
        logic [areg_w-1:0]                    rd;
        logic [areg_w-1:0]                    rs1;
        logic [areg_w-1:0]                    rs2;
        logic                                 wb_valid;
        logic [preg_w-1:0]                    wb_pd;
        logic [xlen-1:0]                      wb_data;
        logic                                 cm_valid;
        logic [preg_w-1:0]                    cm_pd_old;
        logic [read_ports-1:0][preg_w-1:0]    addr;
        logic                                 ready;
        logic [preg_w-1:0]                    ps1;
        logic [preg_w-1:0]                    ps2;
        logic                                 ps1_ready;
        logic                                 ps2_ready;
        logic [preg_w-1:0]                    pd;
        logic [preg_w-1:0]                    pd_old;
        logic [read_ports-1:0][xlen-1:0]      data;
    } record_t;

    logic                              clock;
    logic                              reset;
    logic                              ren_valid;
    logic [areg_w-1:0]                 ren_rd;
    logic [areg_w-1:0]                 ren_rs1;
    logic [areg_w-1:0]                 ren_rs2;
    logic                              ren_ready;
    logic [preg_w-1:0]                 ren_ps1;
    logic [preg_w-1:0]                 ren_ps2;
    logic                              ren_ps1_ready;
    logic                              ren_ps2_ready;
    logic [preg_w-1:0]                 ren_pd;
    logic [preg_w-1:0]                 ren_pd_old;
    logic                              wb_valid;
    logic [preg_w-1:0]                 wb_pd;
    logic [xlen-1:0]                   wb_data;
    logic                              cm_valid;
    logic [preg_w-1:0]                 cm_pd_old;
    logic [read_ports-1:0][preg_w-1:0] rd_addr;
    logic [read_ports-1:0][xlen-1:0]   rd_data;

    record_t recs[$];              // whole golden file
    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;           // per test, cleared on report
    int test_checks = 0;
    int cycles      = 0;
    int limit       = 0;           // zero until the file is loaded

    rename_core uut (.*);

    // ========================================
    // clock and watchdog
    // ========================================
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // 100 ns period
    end

    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_preg(input string what, input logic [preg_w-1:0] got,
                              input logic [preg_w-1:0] exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("MISMATCH at %0t: %s is p%0d, expected p%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input string what, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic string test_name(input int id);
        case (id)
            0:       return "ren_ready low in reset";
            1:       return "allocation order after reset";
            2:       return "source dependency and wakeup";
            3:       return "register file reads and bypass";
            4:       return "free list exhaustion and refill";
            5:       return "source equal to destination";
            default: return "unnamed";
        endcase
    endfunction

    task automatic report_test(input int id);
        $display("test %0d (%s): %0d checks, %0d failed", id, test_name(id),
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // ========================================
    // golden file
    // ========================================
    task automatic load_records(output bit ok);
        int          fd;
        int          got;
        int          line_no;
        string       line;
        logic [31:0] f [25];       // raw hex columns
        record_t     r;
        ok      = 1'b1;
        line_no = 0;
        fd      = $fopen("sim/rename_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open golden file sim/rename_golden.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && ok) begin
                line = "";
                got  = $fgets(line, fd);
                line_no++;
                if (got == 0 || line.len() < 2 || line.getc(0) == "#") continue;   // comment
                got = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                    f[22], f[23], f[24]);
                if (got != 25) begin
                    $display("golden file line %0d is short: %0d of 25 fields", line_no, got);
                    ok = 1'b0;
                end else begin
                    r.test      = f[0][3:0];
                    r.valid     = f[1][0];
                    r.rd        = f[2][areg_w-1:0];
                    r.rs1       = f[3][areg_w-1:0];
                    r.rs2       = f[4][areg_w-1:0];
                    r.wb_valid  = f[5][0];
                    r.wb_pd     = f[6][preg_w-1:0];
                    r.wb_data   = f[7];
                    r.cm_valid  = f[8][0];
                    r.cm_pd_old = f[9][preg_w-1:0];
                    r.ready     = f[14][0];
                    r.ps1       = f[15][preg_w-1:0];
                    r.ps2       = f[16][preg_w-1:0];
                    r.ps1_ready = f[17][0];
                    r.ps2_ready = f[18][0];
                    r.pd        = f[19][preg_w-1:0];
                    r.pd_old    = f[20][preg_w-1:0];
                    for (int p = 0; p < read_ports; p++) begin
                        r.addr[p] = f[10 + p][preg_w-1:0];   // columns a0..a3
                        r.data[p] = f[21 + p];               // columns d0..d3
                    end
                    recs.push_back(r);
                end
            end
            $fclose(fd);
            if (ok && recs.size() == 0) begin
                $display("golden file holds no records");
                ok = 1'b0;
            end
        end
    endtask

    task automatic drive_inputs(input record_t r);
        ren_valid = r.valid;
        ren_rd    = r.rd;
        ren_rs1   = r.rs1;
        ren_rs2   = r.rs2;
        wb_valid  = r.wb_valid;
        wb_pd     = r.wb_pd;
        wb_data   = r.wb_data;
        cm_valid  = r.cm_valid;
        cm_pd_old = r.cm_pd_old;
        rd_addr   = r.addr;
    endtask

    task automatic check_record(input record_t r);
        check_bit("ren_ready", ren_ready, r.ready);
        if (r.valid && r.ready) begin              // rename outputs only on a transfer
            check_preg("ren_ps1", ren_ps1, r.ps1);
            check_preg("ren_ps2", ren_ps2, r.ps2);
            check_bit("ren_ps1_ready", ren_ps1_ready, r.ps1_ready);
            check_bit("ren_ps2_ready", ren_ps2_ready, r.ps2_ready);
            check_preg("ren_pd", ren_pd, r.pd);
            check_preg("ren_pd_old", ren_pd_old, r.pd_old);
        end
        for (int p = 0; p < read_ports; p++) begin
            check_data($sformatf("rd_data[%0d]", p), rd_data[p], r.data[p]);
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin : main
        bit load_ok;
        reset     = 1'b1;
        ren_valid = 1'b0;
        ren_rd    = '0;
        ren_rs1   = '0;
        ren_rs2   = '0;
        wb_valid  = 1'b0;
        wb_pd     = '0;
        wb_data   = '0;
        cm_valid  = 1'b0;
        cm_pd_old = '0;
        rd_addr   = '0;
        load_records(load_ok);
        if (!load_ok) begin
            $display("ERRORS FOUND");
        end else begin
            limit = recs.size() * 2 + 50;
            for (int i = 0; i < 8; i++) begin
                @(negedge clock);
                check_bit("ren_ready in reset", ren_ready, 1'b0);
            end
            report_test(0);
            reset = 1'b0;                          // released on a falling edge
            for (int i = 0; i < recs.size(); i++) begin
                @(negedge clock);
                drive_inputs(recs[i]);
                #40;                               // 10 ns before the rising edge
                check_record(recs[i]);
                if (i == recs.size() - 1 || recs[i + 1].test != recs[i].test) begin
                    report_test(recs[i].test);
                end
            end
            @(negedge clock);
            ren_valid = 1'b0;
            wb_valid  = 1'b0;
            cm_valid  = 1'b0;
            $display("total: %0d checks, %0d mismatches", check_count, error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
        end
        $finish;
    end

endmodule

/* sim/rename_golden.txt */
# test v rd rs1 rs2 | wb_valid wb_pd wb_data | cm_valid cm_pd_old | rd_addr0..3 |
# ready ps1 ps2 ps1_rdy ps2_rdy pd pd_old | rd_data0..3   (all hex, one cycle per line)
1 1 05 01 02 0 00 00000000 0 00 00 05 20 3f 1 01 02 1 1 20 05 00000000 00000000 00000000 00000000
1 1 06 03 04 0 00 00000000 0 00 00 05 20 3f 1 03 04 1 1 21 06 00000000 00000000 00000000 00000000
1 1 07 00 00 0 00 00000000 0 00 00 05 20 3f 1 00 00 1 1 22 07 00000000 00000000 00000000 00000000
2 1 08 05 06 0 00 00000000 0 00 20 21 00 3f 1 20 21 0 0 23 08 00000000 00000000 00000000 00000000
2 1 09 05 08 1 20 12345678 0 00 20 21 00 3f 1 20 23 1 0 24 09 12345678 00000000 00000000 00000000
2 1 0a 05 06 0 00 00000000 0 00 20 21 00 3f 1 20 21 1 0 25 0a 12345678 00000000 00000000 00000000
3 0 00 00 00 1 21 deadbeef 0 00 21 20 00 22 1 00 00 0 0 00 00 deadbeef 12345678 00000000 00000000
3 0 00 00 00 1 20 cafef00d 0 00 20 20 21 00 1 00 00 0 0 00 00 cafef00d cafef00d deadbeef 00000000
3 0 00 00 00 0 00 00000000 0 00 20 21 00 3f 1 00 00 0 0 00 00 cafef00d deadbeef 00000000 00000000
5 1 05 05 05 0 00 00000000 0 00 20 21 00 3f 1 20 20 1 1 26 20 cafef00d deadbeef 00000000 00000000
5 1 06 06 05 0 00 00000000 0 00 20 21 00 3f 1 21 26 1 0 27 21 cafef00d deadbeef 00000000 00000000
4 1 0b 06 00 0 00 00000000 0 00 20 21 00 3f 1 27 00 0 1 28 0b cafef00d deadbeef 00000000 00000000
4 1 0c 0b 00 0 00 00000000 0 00 20 21 00 3f 1 28 00 0 1 29 0c cafef00d deadbeef 00000000 00000000
4 1 0d 0c 00 0 00 00000000 0 00 20 21 00 3f 1 29 00 0 1 2a 0d cafef00d deadbeef 00000000 00000000
4 1 0e 0d 00 0 00 00000000 0 00 20 21 00 3f 1 2a 00 0 1 2b 0e cafef00d deadbeef 00000000 00000000
4 1 0f 0e 00 0 00 00000000 0 00 20 21 00 3f 1 2b 00 0 1 2c 0f cafef00d deadbeef 00000000 00000000
4 1 10 0f 00 0 00 00000000 0 00 20 21 00 3f 1 2c 00 0 1 2d 10 cafef00d deadbeef 00000000 00000000
4 1 11 10 00 0 00 00000000 0 00 20 21 00 3f 1 2d 00 0 1 2e 11 cafef00d deadbeef 00000000 00000000
4 1 12 11 00 0 00 00000000 0 00 20 21 00 3f 1 2e 00 0 1 2f 12 cafef00d deadbeef 00000000 00000000
4 1 13 12 00 0 00 00000000 0 00 20 21 00 3f 1 2f 00 0 1 30 13 cafef00d deadbeef 00000000 00000000
4 1 14 13 00 0 00 00000000 0 00 20 21 00 3f 1 30 00 0 1 31 14 cafef00d deadbeef 00000000 00000000
4 1 15 14 00 0 00 00000000 0 00 20 21 00 3f 1 31 00 0 1 32 15 cafef00d deadbeef 00000000 00000000
4 1 16 15 00 0 00 00000000 0 00 20 21 00 3f 1 32 00 0 1 33 16 cafef00d deadbeef 00000000 00000000
4 1 17 16 00 0 00 00000000 0 00 20 21 00 3f 1 33 00 0 1 34 17 cafef00d deadbeef 00000000 00000000
4 1 18 17 00 0 00 00000000 0 00 20 21 00 3f 1 34 00 0 1 35 18 cafef00d deadbeef 00000000 00000000
4 1 19 18 00 0 00 00000000 0 00 20 21 00 3f 1 35 00 0 1 36 19 cafef00d deadbeef 00000000 00000000
4 1 1a 19 00 0 00 00000000 0 00 20 21 00 3f 1 36 00 0 1 37 1a cafef00d deadbeef 00000000 00000000
4 1 1b 1a 00 0 00 00000000 0 00 20 21 00 3f 1 37 00 0 1 38 1b cafef00d deadbeef 00000000 00000000
4 1 1c 1b 00 0 00 00000000 0 00 20 21 00 3f 1 38 00 0 1 39 1c cafef00d deadbeef 00000000 00000000
4 1 1d 1c 00 0 00 00000000 0 00 20 21 00 3f 1 39 00 0 1 3a 1d cafef00d deadbeef 00000000 00000000
4 1 1e 1d 00 0 00 00000000 0 00 20 21 00 3f 1 3a 00 0 1 3b 1e cafef00d deadbeef 00000000 00000000
4 1 1f 1e 00 0 00 00000000 0 00 20 21 00 3f 1 3b 00 0 1 3c 1f cafef00d deadbeef 00000000 00000000
4 1 01 1f 00 0 00 00000000 0 00 20 21 00 3f 1 3c 00 0 1 3d 01 cafef00d deadbeef 00000000 00000000
4 1 02 01 00 0 00 00000000 0 00 20 21 00 3f 1 3d 00 0 1 3e 02 cafef00d deadbeef 00000000 00000000
4 1 03 02 00 0 00 00000000 0 00 20 21 00 3f 1 3e 00 0 1 3f 03 cafef00d deadbeef 00000000 00000000
4 1 04 00 00 0 00 00000000 0 00 20 21 00 3f 0 00 00 0 0 00 00 cafef00d deadbeef 00000000 00000000
4 1 00 05 06 1 26 0a0b0c0d 0 00 20 21 26 3f 1 26 27 1 0 00 00 cafef00d deadbeef 0a0b0c0d 00000000
4 0 04 00 00 0 00 00000000 1 05 20 21 00 3f 0 00 00 0 0 00 00 cafef00d deadbeef 00000000 00000000
4 1 04 04 00 0 00 00000000 1 06 20 21 00 3f 1 04 00 1 1 05 04 cafef00d deadbeef 00000000 00000000
4 1 04 04 00 0 00 00000000 1 07 20 21 00 3f 1 05 00 0 1 06 05 cafef00d deadbeef 00000000 00000000
4 1 0b 00 00 0 00 00000000 0 00 20 21 00 3f 1 00 00 1 1 07 28 cafef00d deadbeef 00000000 00000000
4 1 0c 00 00 0 00 00000000 0 00 20 21 00 3f 0 00 00 0 0 00 00 cafef00d deadbeef 00000000 00000000
4 0 0c 00 00 0 00 00000000 1 00 20 21 00 3f 0 00 00 0 0 00 00 cafef00d deadbeef 00000000 00000000
4 0 0c 00 00 0 00 00000000 0 00 20 21 00 3f 0 00 00 0 0 00 00 cafef00d deadbeef 00000000 00000000

/* tb.f */
hw/rename_pkg.sv
hw/phys_regfile.sv
hw/free_list.sv
hw/rename_map.sv
hw/rename_core.sv
sim/rename_core_tb.sv

/* run.sh */
#!/bin/sh
# build the rename testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module rename_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrename_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
